//--- design/md_consts.svh
// ==================
// Widths for the RV32M unit. MD_DIV_STEPS must stay a power of two
// since it also sizes the divide step counter.
// ==================

`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// Operand and result width
`define MD_XLEN 32

// One partial-product half
`define MD_HALF 16

// Intermediate word, two sign/carry bits above the word
`define MD_ACC_W 34

// Quotient bits produced by the long divider
`define MD_DIV_STEPS 32

`endif

//--- design/md_pkg.sv
// ==================
// Shared types for the multiply/divide unit
// ==================

package md_pkg;

  // Operation class, signedness comes separately as a 2-bit mode
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Multiply phase, one partial product per cycle
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  // Divide phase
  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

endpackage

//--- design/md_imd_regs.sv
// ==================
// Only one sequencer may write the accumulator in a given cycle
// ==================
`timescale 1ns/1ps
`include "md_consts.svh"

module md_imd_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 acc_we_mul_i,
  input  logic                 acc_we_div_i,
  input  logic [`MD_ACC_W-1:0] acc_d_mul_i,
  input  logic [`MD_ACC_W-1:0] acc_d_div_i,
  input  logic                 den_we_i,
  input  logic [`MD_XLEN-1:0]  den_d_i,
  output logic [`MD_ACC_W-1:0] acc_q_o,
  output logic [`MD_XLEN-1:0]  den_q_o
);

  logic                 acc_we;
  logic [`MD_ACC_W-1:0] acc_d;

  // Writer chosen by its enable
  assign acc_we = acc_we_mul_i | acc_we_div_i;
  assign acc_d  = acc_we_mul_i ? acc_d_mul_i : acc_d_div_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q_o <= '0;
      den_q_o <= '0;
    end else begin
      // Accumulator, or remainder while dividing
      if (acc_we) begin
        acc_q_o <= acc_d;
      end
      // Absolute divisor
      if (den_we_i) begin
        den_q_o <= den_d_i;
      end
    end
  end

endmodule

//--- design/md_mult_seq.sv
// ==================
// Operands must stay stable from start_i until done_o.
// MUL takes 3 cycles including the start cycle, MULH takes 4.
// ==================
`timescale 1ns/1ps
`include "md_consts.svh"

module md_mult_seq (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  md_pkg::md_op_e       op_i,
  input  logic [1:0]           signed_mode_i,
  input  logic [`MD_XLEN-1:0]  op_a_i,
  input  logic [`MD_XLEN-1:0]  op_b_i,
  input  logic [`MD_ACC_W-1:0] acc_q_i,
  output logic                 acc_we_o,
  output logic [`MD_ACC_W-1:0] acc_d_o,
  output logic                 done_o
);

  localparam int XW = `MD_XLEN;
  localparam int HW = `MD_HALF;
  localparam int AW = `MD_ACC_W;

  md_pkg::mult_state_e state_q, state_d;

  logic                 run;
  logic                 is_mull;
  logic                 signed_mult;
  logic [HW-1:0]        a_half;
  logic [HW-1:0]        b_half;
  logic                 sign_a;
  logic                 sign_b;
  logic [AW-1:0]        accum;
  logic signed [AW-1:0] mac_res;

  // ALBL is the rest state, any other phase means an operation is running
  assign run         = start_i | (state_q != md_pkg::ALBL);
  assign is_mull     = (op_i == md_pkg::MD_OP_MULL);
  assign signed_mult = (signed_mode_i != 2'b00);
  assign acc_we_o    = run;

  // Single 17x17 signed multiply-accumulate
  assign mac_res = $signed({sign_a, a_half}) * $signed({sign_b, b_half}) + $signed(accum);

  always_comb begin
    a_half  = op_a_i[HW-1:0];
    b_half  = op_b_i[HW-1:0];
    sign_a  = 1'b0;
    sign_b  = 1'b0;
    accum   = '0;
    acc_d_o = mac_res;
    state_d = state_q;
    done_o  = 1'b0;

    unique case (state_q)
      md_pkg::ALBL: begin
        // al*bl, always unsigned
        state_d = md_pkg::ALBH;
      end

      md_pkg::ALBH: begin
        // al*bh, added to the upper half of al*bl
        b_half = op_b_i[XW-1:HW];
        sign_b = signed_mode_i[1] & op_b_i[XW-1];
        accum  = {{(AW-HW){1'b0}}, acc_q_i[XW-1:HW]};
        if (is_mull) begin
          // Keep the finished low half, carry only the middle bits on
          acc_d_o = {{(AW-XW){1'b0}}, mac_res[HW-1:0], acc_q_i[HW-1:0]};
        end
        state_d = md_pkg::AHBL;
      end

      md_pkg::AHBL: begin
        // ah*bl
        a_half = op_a_i[XW-1:HW];
        sign_a = signed_mode_i[0] & op_a_i[XW-1];
        if (is_mull) begin
          accum   = {{(AW-HW){1'b0}}, acc_q_i[XW-1:HW]};
          acc_d_o = {{(AW-XW){1'b0}}, mac_res[HW-1:0], acc_q_i[HW-1:0]};
          done_o  = 1'b1;
          state_d = md_pkg::ALBL;
        end else begin
          accum   = acc_q_i;
          state_d = md_pkg::AHBH;
        end
      end

      md_pkg::AHBH: begin
        // ah*bh plus the running sum shifted down by a half
        a_half = op_a_i[XW-1:HW];
        b_half = op_b_i[XW-1:HW];
        sign_a = signed_mode_i[0] & op_a_i[XW-1];
        sign_b = signed_mode_i[1] & op_b_i[XW-1];
        accum  = {{(AW-HW-2){signed_mult & acc_q_i[AW-1]}}, acc_q_i[AW-1:HW]};
        // Low word of this sum is the high word of the product
        done_o  = 1'b1;
        state_d = md_pkg::ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::ALBL;
    end else if (run) begin
      state_q <= state_d;
    end
  end

endmodule

//--- design/md_div_seq.sv
// ==================
// Operands must stay stable from start_i until done_o.
// Division by zero finishes early, all other divides take 37 cycles.
// ==================
`timescale 1ns/1ps
`include "md_consts.svh"

module md_div_seq (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  md_pkg::md_op_e       op_i,
  input  logic [1:0]           signed_mode_i,
  input  logic [`MD_XLEN-1:0]  op_a_i,
  input  logic [`MD_XLEN-1:0]  op_b_i,
  input  logic [`MD_ACC_W-1:0] acc_q_i,
  input  logic [`MD_XLEN-1:0]  den_q_i,
  output logic                 acc_we_o,
  output logic                 den_we_o,
  output logic [`MD_ACC_W-1:0] acc_d_o,
  output logic [`MD_XLEN-1:0]  den_d_o,
  output logic                 done_o
);

  localparam int XW = `MD_XLEN;
  localparam int AW = `MD_ACC_W;
  localparam int CW = $clog2(`MD_DIV_STEPS);
  localparam logic [CW-1:0] CNT_INIT = CW'(`MD_DIV_STEPS - 1);

  md_pkg::div_state_e state_q, state_d;

  logic [XW-1:0] num_q, num_d;
  logic [XW-1:0] quot_q, quot_d;
  logic [CW-1:0] cnt_q, cnt_d;
  logic [XW-1:0] sub_a;
  logic [XW-1:0] sub_b;
  logic [XW:0]   sub_res;
  logic          is_div;
  logic          sign_a;
  logic          sign_b;
  logic          div_change_sign;
  logic          is_ge;
  logic [XW-1:0] one_shift;
  logic [XW-1:0] next_rem;
  logic [XW-1:0] next_quot;

  // Own subtractor, bit XW is the borrow
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};

  assign is_div = (op_i == md_pkg::MD_OP_DIV);
  assign sign_a = signed_mode_i[0] & op_a_i[XW-1];
  assign sign_b = signed_mode_i[1] & op_b_i[XW-1];

  // Quotient negated only for a nonzero divisor
  assign div_change_sign = (sign_a ^ sign_b) & (|den_q_i);

  // Shifted remainder can reach 33 bits for unsigned operands
  assign is_ge     = acc_q_i[XW] | ~sub_res[XW];
  assign one_shift = {{(XW-1){1'b0}}, 1'b1} << cnt_q;
  assign next_rem  = is_ge ? sub_res[XW-1:0] : acc_q_i[XW-1:0];
  assign next_quot = is_ge ? (quot_q | one_shift) : quot_q;

  always_comb begin
    state_d  = state_q;
    num_d    = num_q;
    quot_d   = quot_q;
    cnt_d    = cnt_q;
    sub_a    = '0;
    sub_b    = op_b_i;
    acc_we_o = 1'b1;
    acc_d_o  = acc_q_i;
    den_we_o = 1'b0;
    den_d_o  = op_b_i;
    done_o   = 1'b0;

    unique case (state_q)
      md_pkg::IDLE: begin
        // 0 - b is zero only for a zero divisor
        acc_we_o = start_i;
        if (is_div) begin
          acc_d_o = {{(AW-XW){1'b0}}, {XW{1'b1}}};
        end else begin
          acc_d_o = {{(AW-XW){1'b0}}, op_a_i};
        end
        if (start_i) begin
          state_d = (sub_res[XW-1:0] == '0) ? md_pkg::FINISH : md_pkg::ABS_A;
        end
      end

      md_pkg::ABS_A: begin
        sub_b   = op_a_i;
        quot_d  = '0;
        num_d   = sign_a ? sub_res[XW-1:0] : op_a_i;
        state_d = md_pkg::ABS_B;
      end

      md_pkg::ABS_B: begin
        // First remainder is the top numerator bit
        acc_d_o  = {{(AW-1){1'b0}}, num_q[XW-1]};
        den_we_o = 1'b1;
        den_d_o  = sign_b ? sub_res[XW-1:0] : op_b_i;
        cnt_d    = CNT_INIT;
        state_d  = md_pkg::COMP;
      end

      md_pkg::COMP: begin
        sub_a   = acc_q_i[XW-1:0];
        sub_b   = den_q_i;
        cnt_d   = cnt_q - 1'b1;
        // Shift in the next numerator bit
        acc_d_o = {{(AW-XW-1){1'b0}}, next_rem, num_q[cnt_d]};
        quot_d  = next_quot;
        state_d = (cnt_q == CW'(1)) ? md_pkg::LAST : md_pkg::COMP;
      end

      md_pkg::LAST: begin
        sub_a = acc_q_i[XW-1:0];
        sub_b = den_q_i;
        // Quotient replaces the remainder for DIV
        if (is_div) begin
          acc_d_o = {{(AW-XW){1'b0}}, next_quot};
        end else begin
          acc_d_o = {{(AW-XW){1'b0}}, next_rem};
        end
        state_d = md_pkg::CHANGE_SIGN;
      end

      md_pkg::CHANGE_SIGN: begin
        sub_b = acc_q_i[XW-1:0];
        // Remainder follows the dividend's sign
        if ((is_div && div_change_sign) || (!is_div && sign_a)) begin
          acc_d_o = {{(AW-XW){1'b0}}, sub_res[XW-1:0]};
        end
        state_d = md_pkg::FINISH;
      end

      md_pkg::FINISH: begin
        done_o  = 1'b1;
        state_d = md_pkg::IDLE;
      end

      default: begin
        acc_we_o = 1'b0;
        state_d  = md_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    num_q  <= num_d;
    quot_q <= quot_d;
  end

endmodule

//--- design/md_top.sv
// ==================
// Four-phase req/ack, one operation at a time.
// Inputs are sampled once at acceptance, result holds until req_i falls.
// ==================
`timescale 1ns/1ps
`include "md_consts.svh"

module md_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  md_pkg::md_op_e      op_i,
  input  logic [1:0]          signed_mode_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  output logic                ack_o,
  output logic [`MD_XLEN-1:0] result_o
);

  localparam int XW = `MD_XLEN;
  localparam int AW = `MD_ACC_W;

  typedef enum logic [1:0] {
    TOP_IDLE,
    TOP_BUSY,
    TOP_ACK
  } top_state_e;

  top_state_e     state_q;
  md_pkg::md_op_e op_q;
  logic [1:0]     mode_q;
  logic [XW-1:0]  a_q;
  logic [XW-1:0]  b_q;
  logic           start_q;
  logic           is_div;
  logic           mult_start;
  logic           div_start;
  logic           mult_done;
  logic           div_done;
  logic           acc_we_mul;
  logic           acc_we_div;
  logic           den_we;
  logic [AW-1:0]  acc_d_mul;
  logic [AW-1:0]  acc_d_div;
  logic [AW-1:0]  acc_q;
  logic [XW-1:0]  den_d;
  logic [XW-1:0]  den_q;

  assign is_div     = (op_q == md_pkg::MD_OP_DIV) | (op_q == md_pkg::MD_OP_REM);
  assign mult_start = start_q & ~is_div;
  assign div_start  = start_q & is_div;
  assign ack_o      = (state_q == TOP_ACK);

  // Handshake controller
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= TOP_IDLE;
      start_q  <= 1'b0;
      result_o <= '0;
    end else begin
      start_q <= 1'b0;
      unique case (state_q)
        TOP_IDLE: begin
          if (req_i) begin
            start_q <= 1'b1;
            state_q <= TOP_BUSY;
          end
        end
        TOP_BUSY: begin
          // Take the word being written in the done cycle
          if (mult_done || div_done) begin
            result_o <= div_done ? acc_d_div[XW-1:0] : acc_d_mul[XW-1:0];
            state_q  <= TOP_ACK;
          end
        end
        TOP_ACK: begin
          if (!req_i) begin
            state_q <= TOP_IDLE;
          end
        end
        default: begin
          state_q <= TOP_IDLE;
        end
      endcase
    end
  end

  // Operand capture at acceptance
  always_ff @(posedge clk_i) begin
    if (state_q == TOP_IDLE && req_i) begin
      op_q   <= op_i;
      mode_q <= signed_mode_i;
      a_q    <= op_a_i;
      b_q    <= op_b_i;
    end
  end

  md_mult_seq i_md_mult_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (mult_start),
    .op_i          (op_q),
    .signed_mode_i (mode_q),
    .op_a_i        (a_q),
    .op_b_i        (b_q),
    .acc_q_i       (acc_q),
    .acc_we_o      (acc_we_mul),
    .acc_d_o       (acc_d_mul),
    .done_o        (mult_done)
  );

  md_div_seq i_md_div_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (div_start),
    .op_i          (op_q),
    .signed_mode_i (mode_q),
    .op_a_i        (a_q),
    .op_b_i        (b_q),
    .acc_q_i       (acc_q),
    .den_q_i       (den_q),
    .acc_we_o      (acc_we_div),
    .den_we_o      (den_we),
    .acc_d_o       (acc_d_div),
    .den_d_o       (den_d),
    .done_o        (div_done)
  );

  md_imd_regs i_md_imd_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_we_mul_i (acc_we_mul),
    .acc_we_div_i (acc_we_div),
    .acc_d_mul_i  (acc_d_mul),
    .acc_d_div_i  (acc_d_div),
    .den_we_i     (den_we),
    .den_d_i      (den_d),
    .acc_q_o      (acc_q),
    .den_q_o      (den_q)
  );

endmodule

//--- verification/md_tb.sv
// ====================
// Mode bit 0 signs operand a and bit 1 signs operand b
// The run ends at a cycle limit set by the table size
// ====================
`timescale 1ns/1ps
`include "md_consts.svh"

module md_tb;

  localparam int XW          = `MD_XLEN;
  localparam int NUM_RANDOM  = 40;
  localparam int HOLD_CYCLES = 5;
  localparam int SEED        = 32'h7984f758;

  typedef struct {
    string          name;
    md_pkg::md_op_e op;
    logic [1:0]     mode;
    logic [XW-1:0]  a;
    logic [XW-1:0]  b;
    logic [XW-1:0]  exp;
  } entry_t;

  logic           clk_i;
  logic           rst_ni;
  logic           req_i;
  md_pkg::md_op_e op_i;
  logic [1:0]     signed_mode_i;
  logic [XW-1:0]  op_a_i;
  logic [XW-1:0]  op_b_i;
  logic           ack_o;
  logic [XW-1:0]  result_o;

  entry_t table_q[$];
  int     errors      = 0;
  int     checks      = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 100;

  md_top i_md_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .op_i          (op_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ack_o         (ack_o),
    .result_o      (result_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // RISC-V M rules on 64-bit operands with mode bit 0 signing a and bit 1 signing b
  function automatic logic [XW-1:0] ref_result(input md_pkg::md_op_e op,
                                               input logic [1:0] mode,
                                               input logic [XW-1:0] a,
                                               input logic [XW-1:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] prod;
    logic signed [63:0] quot;
    logic signed [63:0] rem;
    sa   = mode[0] ? {{32{a[31]}}, a} : {32'b0, a};
    sb   = mode[1] ? {{32{b[31]}}, b} : {32'b0, b};
    prod = sa * sb;
    if (b == '0) begin
      quot = '1;
      rem  = sa;
    end else begin
      quot = sa / sb;
      rem  = sa % sb;
    end
    case (op)
      md_pkg::MD_OP_MULL: return prod[31:0];
      md_pkg::MD_OP_MULH: return prod[63:32];
      md_pkg::MD_OP_DIV:  return quot[31:0];
      default:            return rem[31:0];
    endcase
  endfunction

  task automatic add_entry(input string name, input md_pkg::md_op_e op, input logic [1:0] mode,
                           input logic [XW-1:0] a, input logic [XW-1:0] b,
                           input logic [XW-1:0] exp);
    entry_t e;
    e.name = name;
    e.op   = op;
    e.mode = mode;
    e.a    = a;
    e.b    = b;
    e.exp  = exp;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    md_pkg::md_op_e op;
    logic [1:0]     mode;
    logic [XW-1:0]  a;
    logic [XW-1:0]  b;
    add_entry("mul_small", md_pkg::MD_OP_MULL, 2'b11, 32'h7, 32'h6, 32'h2a);
    add_entry("mul_neg", md_pkg::MD_OP_MULL, 2'b11, 32'hfffffffd, 32'h5, 32'hfffffff1);
    add_entry("mul_big", md_pkg::MD_OP_MULL, 2'b00, 32'h12345678, 32'h10, 32'h23456780);
    add_entry("mul_ones", md_pkg::MD_OP_MULL, 2'b00, 32'hffffffff, 32'hffffffff, 32'h1);
    add_entry("mul_mixed", md_pkg::MD_OP_MULL, 2'b01, 32'h80000000, 32'h2, 32'h0);
    add_entry("mulh_ss_min", md_pkg::MD_OP_MULH, 2'b11, 32'h80000000, 32'h80000000,
              32'h40000000);
    add_entry("mulh_ss_ones", md_pkg::MD_OP_MULH, 2'b11, 32'hffffffff, 32'hffffffff, 32'h0);
    add_entry("mulh_ss_mix", md_pkg::MD_OP_MULH, 2'b11, 32'h80000000, 32'h7fffffff,
              32'hc0000000);
    add_entry("mulh_ss_small", md_pkg::MD_OP_MULH, 2'b11, 32'hfffffffe, 32'h3, 32'hffffffff);
    add_entry("mulh_su_ones", md_pkg::MD_OP_MULH, 2'b01, 32'hffffffff, 32'hffffffff,
              32'hffffffff);
    add_entry("mulh_su_min", md_pkg::MD_OP_MULH, 2'b01, 32'h80000000, 32'hffffffff,
              32'h80000000);
    add_entry("mulh_uu_ones", md_pkg::MD_OP_MULH, 2'b00, 32'hffffffff, 32'hffffffff,
              32'hfffffffe);
    add_entry("mulh_uu_min", md_pkg::MD_OP_MULH, 2'b00, 32'h80000000, 32'h80000000,
              32'h40000000);
    add_entry("div_pos", md_pkg::MD_OP_DIV, 2'b11, 32'd100, 32'd7, 32'he);
    add_entry("div_neg", md_pkg::MD_OP_DIV, 2'b11, 32'hfffffff9, 32'h2, 32'hfffffffd);
    add_entry("div_ovf", md_pkg::MD_OP_DIV, 2'b11, 32'h80000000, 32'hffffffff, 32'h80000000);
    add_entry("divu_big", md_pkg::MD_OP_DIV, 2'b00, 32'hffffffff, 32'h10, 32'h0fffffff);
    add_entry("divu_three", md_pkg::MD_OP_DIV, 2'b00, 32'hffffffff, 32'h3, 32'h55555555);
    add_entry("rem_neg", md_pkg::MD_OP_REM, 2'b11, 32'hfffffff9, 32'h2, 32'hffffffff);
    add_entry("rem_negdiv", md_pkg::MD_OP_REM, 2'b11, 32'h7, 32'hfffffffe, 32'h1);
    add_entry("rem_ovf", md_pkg::MD_OP_REM, 2'b11, 32'h80000000, 32'hffffffff, 32'h0);
    add_entry("remu_big", md_pkg::MD_OP_REM, 2'b00, 32'hffffffff, 32'h10, 32'hf);
    add_entry("div_zero", md_pkg::MD_OP_DIV, 2'b11, 32'h12345678, 32'h0, 32'hffffffff);
    add_entry("divu_zero", md_pkg::MD_OP_DIV, 2'b00, 32'h5, 32'h0, 32'hffffffff);
    add_entry("rem_zero", md_pkg::MD_OP_REM, 2'b11, 32'h87654321, 32'h0, 32'h87654321);
    add_entry("remu_zero", md_pkg::MD_OP_REM, 2'b00, 32'h87654321, 32'h0, 32'h87654321);
    // Random operations use only the modes RV32M encodes
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op = md_pkg::md_op_e'(2'($urandom));
      a  = $urandom;
      b  = $urandom;
      if ($urandom % 3 == 0) begin
        b = b >> ($urandom % XW);
      end
      if (op == md_pkg::MD_OP_MULL) begin
        mode = 2'($urandom);
      end else if (op == md_pkg::MD_OP_MULH) begin
        case ($urandom % 3)
          0:       mode = 2'b11;
          1:       mode = 2'b01;
          default: mode = 2'b00;
        endcase
      end else begin
        mode = ($urandom % 2 == 0) ? 2'b11 : 2'b00;
      end
      add_entry($sformatf("rand_%0d", i), op, mode, a, b, ref_result(op, mode, a, b));
    end
  endtask

  // Outputs are sampled and inputs driven 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_idle(input int cycles, input string where);
    repeat (cycles) begin
      next_cycle();
      checks++;
      assert (!ack_o) else begin
        errors++;
        $display("ERROR: ack_o rose without a request (%s)", where);
      end
    end
  endtask

  task automatic apply_entry(input entry_t e);
    op_i          = e.op;
    signed_mode_i = e.mode;
    op_a_i        = e.a;
    op_b_i        = e.b;
    req_i         = 1'b1;
    next_cycle();
    while (!ack_o) begin
      next_cycle();
    end
    checks++;
    assert (result_o == e.exp) else begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", e.name, e.exp, result_o);
    end
    // Back-pressure holds the answer while req_i is high
    repeat (HOLD_CYCLES) begin
      next_cycle();
      checks++;
      assert (ack_o) else begin
        errors++;
        $display("ERROR: %s: ack_o fell while req_i was still high", e.name);
      end
      assert (result_o == e.exp) else begin
        errors++;
        $display("mismatch %s_hold: expected %h, actual %h", e.name, e.exp, result_o);
      end
    end
    req_i = 1'b0;
    next_cycle();
    checks++;
    assert (!ack_o) else begin
      errors++;
      $display("ERROR: %s: ack_o still high one cycle after req_i fell", e.name);
    end
    while (ack_o) begin
      next_cycle();
    end
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    op_i          = md_pkg::MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = table_q.size() * 45 + 100;

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    checks++;
    assert (!ack_o) else begin
      errors++;
      $display("ERROR: ack_o is high right after reset");
    end
    assert (result_o == '0) else begin
      errors++;
      $display("mismatch reset: expected %h, actual %h", 32'h0, result_o);
    end
    check_idle(3, "after reset");

    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
      check_idle(2, table_q[i].name);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/md_pkg.sv
design/md_imd_regs.sv
design/md_mult_seq.sv
design/md_div_seq.sv
design/md_top.sv
verification/md_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the md_tb testbench with Verilator and runs it.
# The exit status is 0 only when the testbench reports a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module md_tb -f vlog.f \
  && ./obj_dir/Vmd_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
